// File: alu_pkg.sv
package alu_pkg;

  ////////////////////////////////////////////////////////////
  // Integer datapath constants
  ////////////////////////////////////////////////////////////

  localparam int xlen    = 32;  // Data width
  localparam int shamt_w = 5;   // Shift amount taken from low bits of b

  // Link address increments
  localparam logic [xlen-1:0] pc_incr_full = 4;  // 32-bit instruction
  localparam logic [xlen-1:0] pc_incr_comp = 2;  // 16-bit compressed

  // Core ALU operation select, encoded as the decoder drives it
  typedef enum logic [2:0] {
    op_add = 3'b000,  // a + b
    op_sub = 3'b001,  // a - b
    op_and = 3'b010,  // Bitwise AND
    op_or  = 3'b011,  // Bitwise OR
    op_xor = 3'b100,  // Bitwise XOR
    op_sll = 3'b101,  // Logical left
    op_srl = 3'b110,  // Logical right
    op_sra = 3'b111   // Arithmetic right
  } alu_op_e;

  // Instruction kind, picks which result goes to rd
  typedef enum logic [2:0] {
    kind_alu   = 3'd0,  // Plain alu_op result
    kind_lui   = 3'd1,  // imm
    kind_auipc = 3'd2,  // pc + imm
    kind_jal   = 3'd3,  // Link address
    kind_jalr  = 3'd4,  // Link address
    kind_slt   = 3'd5,  // Signed compare
    kind_sltu  = 3'd6,  // Unsigned compare
    kind_csr   = 3'd7   // Result comes from the CSR side
  } ex_kind_e;

endpackage : alu_pkg

// File: csr_pkg.sv
package csr_pkg;

  ////////////////////////////////////////////////////////////
  // Machine CSR definitions
  ////////////////////////////////////////////////////////////

  localparam int csr_addr_w = 12;  // CSR address field
  localparam int zimm_w     = 5;   // Immediate operand of the i-forms

  // Supported CSRs, everything else is a miss
  localparam logic [csr_addr_w-1:0] csr_mtvec_addr    = 12'h305;
  localparam logic [csr_addr_w-1:0] csr_mscratch_addr = 12'h340;
  localparam logic [csr_addr_w-1:0] csr_mepc_addr     = 12'h341;

  // Zicsr operations
  // Bit 2 set means the operand is zimm, not rs1
  typedef enum logic [2:0] {
    csr_none = 3'd0,  // No CSR access
    csr_rw   = 3'd1,  // Write rs1
    csr_rs   = 3'd2,  // Set bits from rs1
    csr_rc   = 3'd3,  // Clear bits from rs1
    csr_rwi  = 3'd5,  // Write zimm
    csr_rsi  = 3'd6,  // Set bits from zimm
    csr_rci  = 3'd7   // Clear bits from zimm
  } csr_op_e;

endpackage : csr_pkg

// File: int_alu.sv
`timescale 1ns/100ps

module int_alu (
  input  alu_pkg::ex_kind_e        kind,
  input  alu_pkg::alu_op_e         alu_op,
  input  logic                     use_imm,     // b from imm, else rs2
  input  logic                     compressed,  // 16-bit instruction
  input  logic [alu_pkg::xlen-1:0] rs1_val,
  input  logic [alu_pkg::xlen-1:0] rs2_val,
  input  logic [alu_pkg::xlen-1:0] imm,
  input  logic [alu_pkg::xlen-1:0] pc,
  output logic [alu_pkg::xlen-1:0] alu_res,
  output logic                     alu_lt_u     // rs1 < b, unsigned
);

  import alu_pkg::*;

  logic [xlen-1:0]    op_b;       // Second operand
  logic [shamt_w-1:0] shamt;
  logic [xlen-1:0]    core_res;   // alu_op result
  logic [xlen-1:0]    link_addr;  // Return address for jal/jalr
  logic [xlen-1:0]    pc_incr;
  logic               lt_s;       // Signed compare

  ////////////////////////////////////////////////////////////
  // Operands
  ////////////////////////////////////////////////////////////

  assign op_b  = use_imm ? imm : rs2_val;
  assign shamt = op_b[shamt_w-1:0];  // Low 5 bits only

  // Compares, unsigned one also leaves the block for branches
  assign lt_s     = $signed(rs1_val) < $signed(op_b);
  assign alu_lt_u = rs1_val < op_b;

  // Next sequential pc
  assign pc_incr   = compressed ? pc_incr_comp : pc_incr_full;
  assign link_addr = pc + pc_incr;

  ////////////////////////////////////////////////////////////
  // Core operation
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_op)
      op_add:  core_res = rs1_val + op_b;
      op_sub:  core_res = rs1_val - op_b;
      op_and:  core_res = rs1_val & op_b;
      op_or:   core_res = rs1_val | op_b;
      op_xor:  core_res = rs1_val ^ op_b;
      op_sll:  core_res = rs1_val << shamt;
      op_srl:  core_res = rs1_val >> shamt;
      op_sra:  core_res = $unsigned($signed(rs1_val) >>> shamt);  // Sign fill
      default: core_res = '0;
    endcase
  end

  // Result by instruction kind
  always_comb begin
    case (kind)
      kind_lui:   alu_res = imm;       // Upper immediate as is
      kind_auipc: alu_res = pc + imm;  // Full pc
      kind_jal,
      kind_jalr:  alu_res = link_addr;
      kind_slt:   alu_res = {{(xlen-1){1'b0}}, lt_s};
      kind_sltu:  alu_res = {{(xlen-1){1'b0}}, alu_lt_u};
      default:    alu_res = core_res;  // kind_alu, and don't-care for csr
    endcase
  end

endmodule : int_alu

// File: csr_unit.sv
`timescale 1ns/100ps

module csr_unit (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           valid,      // Instruction strobe
  input  csr_pkg::csr_op_e               csr_op,
  input  logic [csr_pkg::csr_addr_w-1:0] csr_addr,
  input  logic [alu_pkg::xlen-1:0]       rs1_val,
  input  logic [csr_pkg::zimm_w-1:0]     zimm,
  output logic                           csr_active, // CSR op this cycle
  output logic [alu_pkg::xlen-1:0]       csr_rdata,  // Old value
  output logic                           csr_miss    // Unsupported address
);

  import alu_pkg::*;
  import csr_pkg::*;

  logic [xlen-1:0] mtvec_q;
  logic [xlen-1:0] mscratch_q;
  logic [xlen-1:0] mepc_q;

  logic            sel_mtvec;
  logic            sel_mscratch;
  logic            sel_mepc;
  logic            addr_hit;
  logic            imm_form;   // Operand from zimm
  logic [xlen-1:0] operand;
  logic [xlen-1:0] old_val;
  logic [xlen-1:0] new_val;

  ////////////////////////////////////////////////////////////
  // Decode and read
  ////////////////////////////////////////////////////////////

  assign sel_mtvec    = (csr_addr == csr_mtvec_addr);
  assign sel_mscratch = (csr_addr == csr_mscratch_addr);
  assign sel_mepc     = (csr_addr == csr_mepc_addr);
  assign addr_hit     = sel_mtvec | sel_mscratch | sel_mepc;

  assign csr_active = valid && (csr_op != csr_none);
  assign csr_miss   = csr_active && !addr_hit;

  // Old value, zero when nothing matches
  always_comb begin
    old_val = '0;
    if (sel_mtvec)    old_val = mtvec_q;
    if (sel_mscratch) old_val = mscratch_q;
    if (sel_mepc)     old_val = mepc_q;
  end

  assign csr_rdata = old_val;

  // i-forms take the zero-extended zimm
  assign imm_form = (csr_op == csr_rwi) || (csr_op == csr_rsi) || (csr_op == csr_rci);
  assign operand  = imm_form ? {{(xlen-zimm_w){1'b0}}, zimm} : rs1_val;

  // Read-modify-write
  always_comb begin
    case (csr_op)
      csr_rw, csr_rwi: new_val = operand;
      csr_rs, csr_rsi: new_val = old_val | operand;
      csr_rc, csr_rci: new_val = old_val & ~operand;  // Clear set bits
      default:         new_val = old_val;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Registers, commit on the sampling edge
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
    end else if (csr_active) begin
      if (sel_mtvec)    mtvec_q    <= {new_val[xlen-1:2], 2'b00};  // Aligned base
      if (sel_mscratch) mscratch_q <= new_val;
      if (sel_mepc)     mepc_q     <= {new_val[xlen-1:2], 2'b00};  // Aligned epc
    end
  end

endmodule : csr_unit

// File: ex_writeback.sv
`timescale 1ns/100ps

module ex_writeback (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     valid,
  input  logic                     csr_active,  // CSR result wins
  input  logic [alu_pkg::xlen-1:0] csr_rdata,
  input  logic                     csr_miss,
  input  logic [alu_pkg::xlen-1:0] alu_res,
  input  logic                     alu_lt_u,
  output logic                     wb_valid,
  output logic [alu_pkg::xlen-1:0] rd_data,
  output logic                     lt_u,
  output logic                     csr_illegal
);

  logic [alu_pkg::xlen-1:0] wb_sel;  // Destination value this cycle

  // CSR instructions write the old CSR value to rd
  assign wb_sel = csr_active ? csr_rdata : alu_res;

  ////////////////////////////////////////////////////////////
  // Write-back register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid    <= 1'b0;
      csr_illegal <= 1'b0;
      rd_data     <= '0;
      lt_u        <= 1'b0;
    end else begin
      wb_valid    <= valid;
      csr_illegal <= csr_miss;  // Already qualified by valid
      if (valid) begin        // Payload holds across bubbles
        rd_data <= wb_sel;
        lt_u    <= alu_lt_u;
      end
    end
  end

endmodule : ex_writeback

// File: ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           valid,
  input  alu_pkg::ex_kind_e              kind,
  input  alu_pkg::alu_op_e               alu_op,
  input  logic                           use_imm,
  input  logic                           compressed,
  input  logic [alu_pkg::xlen-1:0]       rs1_val,
  input  logic [alu_pkg::xlen-1:0]       rs2_val,
  input  logic [alu_pkg::xlen-1:0]       imm,
  input  logic [alu_pkg::xlen-1:0]       pc,
  input  csr_pkg::csr_op_e               csr_op,
  input  logic [csr_pkg::csr_addr_w-1:0] csr_addr,
  input  logic [csr_pkg::zimm_w-1:0]     zimm,
  output logic                           wb_valid,
  output logic [alu_pkg::xlen-1:0]       rd_data,
  output logic                           lt_u,
  output logic                           csr_illegal
);

  import alu_pkg::*;

  logic [xlen-1:0] alu_res;
  logic            alu_lt_u;
  logic            csr_active;
  logic [xlen-1:0] csr_rdata;
  logic            csr_miss;

  // Integer side, combinational
  int_alu int_alu_inst (
    .kind       (kind),
    .alu_op     (alu_op),
    .use_imm    (use_imm),
    .compressed (compressed),
    .rs1_val    (rs1_val),
    .rs2_val    (rs2_val),
    .imm        (imm),
    .pc         (pc),
    .alu_res    (alu_res),
    .alu_lt_u   (alu_lt_u)
  );

  // CSR side, commits on the same edge
  csr_unit csr_unit_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid      (valid),
    .csr_op     (csr_op),
    .csr_addr   (csr_addr),
    .rs1_val    (rs1_val),
    .zimm       (zimm),
    .csr_active (csr_active),
    .csr_rdata  (csr_rdata),
    .csr_miss   (csr_miss)
  );

  ex_writeback ex_writeback_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid       (valid),
    .csr_active  (csr_active),
    .csr_rdata   (csr_rdata),
    .csr_miss    (csr_miss),
    .alu_res     (alu_res),
    .alu_lt_u    (alu_lt_u),
    .wb_valid    (wb_valid),
    .rd_data     (rd_data),
    .lt_u        (lt_u),
    .csr_illegal (csr_illegal)
  );

endmodule : ex_stage

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // Half period
  end

  // Reset low for 8 cycles, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule : tb_clock_gen

// File: ex_stage_properties.sv
`timescale 1ns/100ps

module ex_stage_properties (
  input logic clk,
  input logic rst_n,
  input logic valid,
  input logic wb_valid,
  input logic csr_illegal
);

  ////////////////////////////////////////////////////////////
  // Write-back register behavior
  ////////////////////////////////////////////////////////////

  // Nothing leaves the stage while reset is held
  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !wb_valid)
    else $error("wb_valid high while reset is asserted");

  // One clock of latency from the strobe
  a_valid_delay: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> (wb_valid == $past(valid)))
    else $error("wb_valid is not valid delayed by one cycle");

  // Illegal flag only rides on a real instruction
  a_illegal_valid: assert property (@(posedge clk) disable iff (!rst_n)
    csr_illegal |-> wb_valid)
    else $error("csr_illegal set without wb_valid");

endmodule : ex_stage_properties

bind ex_stage ex_stage_properties ex_stage_properties_inst (
  .clk         (clk),
  .rst_n       (rst_n),
  .valid       (valid),
  .wb_valid    (wb_valid),
  .csr_illegal (csr_illegal)
);

// File: ex_stage_tb.sv
`timescale 1ns/100ps

module ex_stage_tb;

  import alu_pkg::*;
  import csr_pkg::*;

  // One instruction and what should come back a cycle later
  typedef struct {
    string                 name;
    logic                  vld;       // Strobe for this cycle
    ex_kind_e              kind;
    alu_op_e               alu_op;
    logic                  use_imm;
    logic                  compressed;
    logic [xlen-1:0]       rs1_val;
    logic [xlen-1:0]       rs2_val;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       pc;
    csr_op_e               csr_op;
    logic [csr_addr_w-1:0] csr_addr;
    logic [zimm_w-1:0]     zimm;
    logic [xlen-1:0]       exp_rd;
    logic                  exp_lt_u;
    logic                  exp_ill;
  } row_t;

  logic                  clk;
  logic                  rst_n;
  logic                  valid;
  ex_kind_e              kind;
  alu_op_e               alu_op;
  logic                  use_imm;
  logic                  compressed;
  logic [xlen-1:0]       rs1_val;
  logic [xlen-1:0]       rs2_val;
  logic [xlen-1:0]       imm;
  logic [xlen-1:0]       pc;
  csr_op_e               csr_op;
  logic [csr_addr_w-1:0] csr_addr;
  logic [zimm_w-1:0]     zimm;
  logic                  wb_valid;
  logic [xlen-1:0]       rd_data;
  logic                  lt_u;
  logic                  csr_illegal;

  row_t            rows[$];   // Stimulus table
  logic [31:0]     lfsr;
  logic [xlen-1:0] held_rd;   // Last rd_data that should be visible
  logic            held_ltu;
  logic            released;
  int              n_checks;
  int              n_errors;

  tb_clock_gen tb_clock_gen_inst (
    .clk   (clk),
    .rst_n (rst_n)
  );

  ex_stage ex_stage_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid       (valid),
    .kind        (kind),
    .alu_op      (alu_op),
    .use_imm     (use_imm),
    .compressed  (compressed),
    .rs1_val     (rs1_val),
    .rs2_val     (rs2_val),
    .imm         (imm),
    .pc          (pc),
    .csr_op      (csr_op),
    .csr_addr    (csr_addr),
    .zimm        (zimm),
    .wb_valid    (wb_valid),
    .rd_data     (rd_data),
    .lt_u        (lt_u),
    .csr_illegal (csr_illegal)
  );

  ////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};  // One step per bit
    end
  endtask

  function automatic logic [xlen-1:0] alu_ref(input alu_op_e op, input logic [xlen-1:0] a,
                                              input logic [xlen-1:0] b);
    logic [4:0] s;
    s = b[4:0];
    case (op)
      op_add: return a + b;
      op_sub: return a - b;
      op_and: return a & b;
      op_or:  return a | b;
      op_xor: return a ^ b;
      op_sll: return a << s;
      op_srl: return a >> s;
      default: return (a >> s) | (a[31] ? ~(32'hffff_ffff >> s) : 32'h0);  // Sign fill
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Table building
  ////////////////////////////////////////////////////////////

  function automatic row_t blank_row(input string name);
    row_t r;
    r.name       = name;
    r.vld        = 1'b1;
    r.kind       = kind_alu;
    r.alu_op     = op_add;
    r.use_imm    = 1'b0;
    r.compressed = 1'b0;
    r.rs1_val    = '0;
    r.rs2_val    = '0;
    r.imm        = '0;
    r.pc         = 32'h0000_0400;
    r.csr_op     = csr_none;
    r.csr_addr   = '0;
    r.zimm       = '0;
    r.exp_rd     = '0;
    r.exp_lt_u   = 1'b0;
    r.exp_ill    = 1'b0;
    return r;
  endfunction

  // Unused b source gets the inverse so a wrong select shows
  task automatic alu_row(input string name, input alu_op_e op, input logic sel_imm,
                         input logic [xlen-1:0] a, input logic [xlen-1:0] b,
                         input logic [xlen-1:0] exp_rd, input logic exp_ltu);
    row_t r;
    r          = blank_row(name);
    r.alu_op   = op;
    r.use_imm  = sel_imm;
    r.rs1_val  = a;
    r.rs2_val  = sel_imm ? ~b : b;
    r.imm      = sel_imm ? b : ~b;
    r.exp_rd   = exp_rd;
    r.exp_lt_u = exp_ltu;
    rows.push_back(r);
  endtask

  task automatic kind_row(input string name, input ex_kind_e k, input logic comp,
                          input logic [xlen-1:0] a, input logic [xlen-1:0] b,
                          input logic [xlen-1:0] pc_val, input logic [xlen-1:0] exp_rd,
                          input logic exp_ltu);
    row_t r;
    r            = blank_row(name);
    r.kind       = k;
    r.use_imm    = 1'b1;
    r.compressed = comp;
    r.rs1_val    = a;
    r.rs2_val    = ~b;
    r.imm        = b;
    r.pc         = pc_val;
    r.exp_rd     = exp_rd;
    r.exp_lt_u   = exp_ltu;
    rows.push_back(r);
  endtask

  // b is rs2 = 0, so lt_u is always 0
  task automatic csr_row(input string name, input csr_op_e op,
                         input logic [csr_addr_w-1:0] addr, input logic [xlen-1:0] a,
                         input logic [zimm_w-1:0] z, input logic [xlen-1:0] exp_rd,
                         input logic exp_ill);
    row_t r;
    r          = blank_row(name);
    r.kind     = kind_csr;
    r.csr_op   = op;
    r.csr_addr = addr;
    r.rs1_val  = a;
    r.zimm     = z;
    r.exp_rd   = exp_rd;
    r.exp_ill  = exp_ill;
    rows.push_back(r);
  endtask

  // Strobe low with a CSR write on the bus that must not commit or flag
  task automatic idle_row(input string name, input logic [csr_addr_w-1:0] addr);
    row_t r;
    r          = blank_row(name);
    r.vld      = 1'b0;
    r.kind     = kind_csr;
    r.csr_op   = csr_rw;
    r.csr_addr = addr;
    r.rs1_val  = 32'hdead_dead;
    rows.push_back(r);
  endtask

  task automatic build_directed_rows();
    alu_row("add_reg",  op_add, 1'b0, 32'h0000_0005, 32'h0000_0007, 32'h0000_000c, 1'b1);
    alu_row("add_imm",  op_add, 1'b1, 32'hffff_fff0, 32'h0000_0020, 32'h0000_0010, 1'b0);
    alu_row("sub_reg",  op_sub, 1'b0, 32'h0000_0003, 32'h0000_0005, 32'hffff_fffe, 1'b1);
    alu_row("sub_imm",  op_sub, 1'b1, 32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 1'b1);
    alu_row("and_reg",  op_and, 1'b0, 32'hff00_ff00, 32'h0f0f_0f0f, 32'h0f00_0f00, 1'b0);
    alu_row("and_imm",  op_and, 1'b1, 32'hf0f0_1234, 32'h0ff0_00ff, 32'h00f0_0034, 1'b0);
    alu_row("or_reg",   op_or,  1'b0, 32'h1200_0034, 32'h0056_7800, 32'h1256_7834, 1'b0);
    alu_row("or_imm",   op_or,  1'b1, 32'h0000_0000, 32'h0000_0abc, 32'h0000_0abc, 1'b1);
    alu_row("xor_reg",  op_xor, 1'b0, 32'h1234_5678, 32'h1234_5678, 32'h0000_0000, 1'b0);
    alu_row("xor_imm",  op_xor, 1'b1, 32'haaaa_5555, 32'hffff_0000, 32'h5555_5555, 1'b1);
    alu_row("sll_0",    op_sll, 1'b1, 32'h8000_0001, 32'h0000_0000, 32'h8000_0001, 1'b0);
    alu_row("sll_31",   op_sll, 1'b0, 32'h0000_0003, 32'h0000_001f, 32'h8000_0000, 1'b1);
    alu_row("sll_low5", op_sll, 1'b0, 32'h0000_0001, 32'h0000_0024, 32'h0000_0010, 1'b1);
    alu_row("srl_31",   op_srl, 1'b1, 32'h8000_0000, 32'h0000_001f, 32'h0000_0001, 1'b0);
    alu_row("srl_0",    op_srl, 1'b0, 32'hdead_beef, 32'h0000_0000, 32'hdead_beef, 1'b0);
    alu_row("sra_neg",  op_sra, 1'b0, 32'h8000_0000, 32'h0000_0004, 32'hf800_0000, 1'b0);
    alu_row("sra_31",   op_sra, 1'b1, 32'hffff_fff0, 32'h0000_001f, 32'hffff_ffff, 1'b0);
    alu_row("sra_pos",  op_sra, 1'b0, 32'h7000_0000, 32'h0000_0004, 32'h0700_0000, 1'b0);
    // Upper immediates and link addresses
    kind_row("lui", kind_lui, 1'b0, 32'h0000_0010, 32'h1234_5000, 32'h0000_1000,
             32'h1234_5000, 1'b1);
    kind_row("auipc", kind_auipc, 1'b0, 32'h0, 32'h0000_3000, 32'h8000_0ffc,
             32'h8000_3ffc, 1'b1);
    kind_row("auipc_wrap", kind_auipc, 1'b0, 32'hffff_ffff, 32'hffff_f000, 32'h0000_2000,
             32'h0000_1000, 1'b0);
    kind_row("jal", kind_jal, 1'b0, 32'h0, 32'h0000_0100, 32'h0000_4000, 32'h0000_4004, 1'b1);
    kind_row("jal_c", kind_jal, 1'b1, 32'h0, 32'h0000_0100, 32'h0000_4000, 32'h0000_4002, 1'b1);
    kind_row("jalr", kind_jalr, 1'b0, 32'h0000_8000, 32'h0000_0010, 32'h0000_5ffe,
             32'h0000_6002, 1'b0);
    kind_row("jalr_c", kind_jalr, 1'b1, 32'h0000_8000, 32'h0000_0010, 32'hffff_fffe,
             32'h0000_0000, 1'b0);
    // Signed and unsigned order disagree
    kind_row("slt_neg",  kind_slt,  1'b0, 32'hffff_ffff, 32'h1, 32'h0, 32'h1, 1'b0);
    kind_row("sltu_neg", kind_sltu, 1'b0, 32'hffff_ffff, 32'h1, 32'h0, 32'h0, 1'b0);
    kind_row("slt_pos",  kind_slt,  1'b0, 32'h1, 32'h8000_0000, 32'h0, 32'h0, 1'b1);
    kind_row("sltu_pos", kind_sltu, 1'b0, 32'h1, 32'h8000_0000, 32'h0, 32'h1, 1'b1);
    // mscratch read-modify-write chain, rd gets the old value
    csr_row("rw_msc",   csr_rw, csr_mscratch_addr, 32'hcafe_f00d, 5'h0, 32'h0, 1'b0);
    csr_row("rs_msc",   csr_rs, csr_mscratch_addr, 32'h0000_0ff0, 5'h0, 32'hcafe_f00d, 1'b0);
    csr_row("rc_msc",   csr_rc, csr_mscratch_addr, 32'hcafe_0000, 5'h0, 32'hcafe_fffd, 1'b0);
    csr_row("read_msc", csr_rs, csr_mscratch_addr, 32'h0, 5'h0, 32'h0000_fffd, 1'b0);
    // mepc via zimm, bits 1:0 stay clear
    csr_row("rwi_mepc",  csr_rwi, csr_mepc_addr, 32'hffff_ffff, 5'h1f, 32'h0, 1'b0);
    csr_row("rsi_mepc",  csr_rsi, csr_mepc_addr, 32'hffff_ffff, 5'h03, 32'h0000_001c, 1'b0);
    csr_row("rci_mepc",  csr_rci, csr_mepc_addr, 32'hffff_ffff, 5'h0c, 32'h0000_001c, 1'b0);
    csr_row("read_mepc", csr_rs,  csr_mepc_addr, 32'h0, 5'h0, 32'h0000_0010, 1'b0);
    csr_row("rw_mtvec",  csr_rw,  csr_mtvec_addr, 32'h0000_1003, 5'h0, 32'h0, 1'b0);
    // Misses, then proof that nothing moved
    csr_row("bad_addr",   csr_rw,  12'h7c0, 32'h1111_1111, 5'h0, 32'h0, 1'b1);
    csr_row("bad_addr_i", csr_rsi, 12'h342, 32'h0, 5'h1f, 32'h0, 1'b1);
    idle_row("idle_csr", csr_mscratch_addr);
    csr_row("read_mtvec", csr_rs, csr_mtvec_addr,    32'h0, 5'h0, 32'h0000_1000, 1'b0);
    csr_row("read_msc2",  csr_rs, csr_mscratch_addr, 32'h0, 5'h0, 32'h0000_fffd, 1'b0);
    csr_row("read_mepc2", csr_rs, csr_mepc_addr,     32'h0, 5'h0, 32'h0000_0010, 1'b0);
  endtask

  task automatic build_random_rows();
    logic [31:0] op_bits;
    logic [31:0] imm_bit;
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < 200; i++) begin
      draw_bits(3, op_bits);
      draw_bits(1, imm_bit);
      draw_bits(32, a);
      draw_bits(32, b);
      alu_row($sformatf("rand_%0d", i), alu_op_e'(op_bits[2:0]), imm_bit[0], a, b,
              alu_ref(alu_op_e'(op_bits[2:0]), a, b), a < b);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Drive and check
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input string what,
                                 input logic [xlen-1:0] exp, input logic [xlen-1:0] act);
    n_errors++;
    $display("Fail %s %s: expected %h, actual %h", name, what, exp, act);
  endtask

  task automatic drive_row(input row_t r);
    valid      = r.vld;
    kind       = r.kind;
    alu_op     = r.alu_op;
    use_imm    = r.use_imm;
    compressed = r.compressed;
    rs1_val    = r.rs1_val;
    rs2_val    = r.rs2_val;
    imm        = r.imm;
    pc         = r.pc;
    csr_op     = r.csr_op;
    csr_addr   = r.csr_addr;
    zimm       = r.zimm;
  endtask

  // Idle rows expect the payload to hold
  task automatic check_row(input row_t r);
    logic [xlen-1:0] e_rd;
    logic            e_ltu;
    logic            e_ill;
    e_rd  = r.vld ? r.exp_rd : held_rd;
    e_ltu = r.vld ? r.exp_lt_u : held_ltu;
    e_ill = r.vld ? r.exp_ill : 1'b0;
    n_checks++;
    if (wb_valid !== r.vld) report_mismatch(r.name, "wb_valid", 32'(r.vld), 32'(wb_valid));
    if (rd_data !== e_rd) report_mismatch(r.name, "rd_data", e_rd, rd_data);
    if (lt_u !== e_ltu) report_mismatch(r.name, "lt_u", 32'(e_ltu), 32'(lt_u));
    if (csr_illegal !== e_ill) report_mismatch(r.name, "csr_illegal", 32'(e_ill),
                                               32'(csr_illegal));
    held_rd  = e_rd;
    held_ltu = e_ltu;
  endtask

  task automatic wait_for_reset(output logic done);
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < 20) begin  // Own timeout
      @(posedge clk);
      cycles++;
    end
    done = (rst_n === 1'b1);
  endtask

  task automatic check_reset_values();
    n_checks++;
    if (wb_valid !== 1'b0) report_mismatch("after_reset", "wb_valid", 32'h0, 32'(wb_valid));
    if (rd_data !== '0) report_mismatch("after_reset", "rd_data", 32'h0, rd_data);
    if (csr_illegal !== 1'b0) report_mismatch("after_reset", "csr_illegal", 32'h0,
                                              32'(csr_illegal));
  endtask

  // One row per cycle, each checked on the next falling edge
  task automatic apply_rows();
    for (int i = 0; i < rows.size(); i++) begin
      @(negedge clk);
      if (i > 0) check_row(rows[i-1]);
      drive_row(rows[i]);
    end
    @(negedge clk);
    check_row(rows[rows.size()-1]);
    valid = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    valid      = 1'b0;
    kind       = kind_alu;
    alu_op     = op_add;
    use_imm    = 1'b0;
    compressed = 1'b0;
    rs1_val    = '0;
    rs2_val    = '0;
    imm        = '0;
    pc         = '0;
    csr_op     = csr_none;
    csr_addr   = '0;
    zimm       = '0;
    lfsr       = 32'h1d03_b23e;
    held_rd    = '0;
    held_ltu   = 1'b0;
    n_checks   = 0;
    n_errors   = 0;

    build_directed_rows();
    build_random_rows();
    idle_row("idle_end", 12'h7c0);  // Final bubble on an unsupported address

    wait_for_reset(released);
    if (!released) begin
      $display("Reset was never released, stopping the run");
      n_errors++;
    end else begin
      @(negedge clk);
      check_reset_values();
      apply_rows();
    end
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule : ex_stage_tb

// File: compile.f
alu_pkg.sv
csr_pkg.sv
int_alu.sv
csr_unit.sv
ex_writeback.sv
ex_stage.sv
tb_clock_gen.sv
ex_stage_properties.sv
ex_stage_tb.sv

// File: Makefile
# Verilator build and run for the execute stage testbench

TOP := ex_stage_tb
SIM := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): compile.f $(wildcard *.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f

# Pass only if the pass message shows up in the output
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
